//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // --------------------
    // geometry
    // --------------------
    localparam int WAYS        = 4;
    localparam int SETS        = 16;
    localparam int SET_BITS    = 4;
    localparam int TAG_BITS    = 8;
    // tag sits above the set index, no offset field
    localparam int ADDR_BITS   = TAG_BITS + SET_BITS;
    localparam int DATA_BITS   = 16;
    localparam int RRPV_BITS   = 2;
    localparam logic [RRPV_BITS-1:0] RRPV_MAX    = '1;
    localparam logic [RRPV_BITS-1:0] RRPV_INSERT = 2'd2;

    // --------------------
    // types
    // --------------------
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [SET_BITS-1:0]  set_t;
    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [WAYS-1:0]      way_vec_t;
    typedef logic [RRPV_BITS-1:0] rrpv_t;

    typedef enum logic [0:0] {
        OP_FETCH = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    // request from the PE
    typedef struct packed {
        op_t   op;
        addr_t addr;
        data_t data;
    } req_t;

    // one write-back word to DRAM
    typedef struct packed {
        addr_t addr;
        data_t data;
    } wb_t;

    // per-way bookkeeping
    typedef struct packed {
        logic  valid;
        logic  dirty;
        rrpv_t rrpv;
    } line_state_t;

endpackage

`default_nettype wire

//--- verilog/way_array.sv
`timescale 1ns/1ps
`default_nettype none

module way_array #(
    parameter type payload_t = cache_pkg::tag_t
) (
    input  wire                   i_clk,
    input  wire  cache_pkg::set_t i_set,
    input  wire                   i_rd_en,
    input  wire                   i_wr_en,
    input  wire  payload_t        i_wr_data,
    output payload_t              o_rd_data
);

    import cache_pkg::*;

    payload_t mem [SETS];

    // registered read, one set per cycle
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_set];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_set] <= i_wr_data;
        end
    end

    // controller never reads and writes the same cycle
    // since lookups only start from idle
    assert property (@(posedge i_clk)
        !$isunknown({i_rd_en, i_wr_en}) |-> !(i_rd_en && i_wr_en))
        else $error("way_array: read and write in the same cycle");

endmodule

`default_nettype wire

//--- verilog/tag_match.sv
`timescale 1ns/1ps
`default_nettype none

module tag_match (
    input  wire  cache_pkg::tag_t                       i_tag,
    input  wire  cache_pkg::tag_t  [cache_pkg::WAYS-1:0] i_way_tags,
    input  wire  cache_pkg::data_t [cache_pkg::WAYS-1:0] i_way_data,
    input  wire  cache_pkg::way_vec_t                   i_valid,
    output cache_pkg::way_vec_t                         o_hit_way,
    output logic                                        o_hit,
    output cache_pkg::data_t                            o_hit_data
);

    import cache_pkg::*;

    // compare per way, masked by valid
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            o_hit_way[w] = i_valid[w] && (i_way_tags[w] == i_tag);
        end
    end

    assign o_hit = |o_hit_way;

    // and-or select of the hit way's word
    always_comb begin
        o_hit_data = '0;
        for (int w = 0; w < WAYS; w++) begin
            o_hit_data = o_hit_data | (i_way_data[w] & {DATA_BITS{o_hit_way[w]}});
        end
    end

    // a tag is only ever allocated on a miss, so a set never
    // holds the same valid tag twice
    always_comb begin
        if (!$isunknown(o_hit_way)) begin
            assert final ($onehot0(o_hit_way))
                else $error("tag_match: more than one way hits");
        end
    end

endmodule

`default_nettype wire

//--- verilog/rrip_state.sv
`timescale 1ns/1ps
`default_nettype none

module rrip_state (
    input  wire                          i_clk,
    input  wire                          i_nreset,
    input  wire  cache_pkg::set_t        i_set,
    input  wire                          i_update,
    input  wire  cache_pkg::way_vec_t    i_update_way,
    input  wire                          i_update_hit,
    input  wire                          i_set_dirty,
    output cache_pkg::way_vec_t          o_victim,
    output cache_pkg::line_state_t       o_victim_state,
    output cache_pkg::way_vec_t          o_valid
);

    import cache_pkg::*;

    line_state_t [WAYS-1:0] lines_q [SETS];
    line_state_t [WAYS-1:0] cur;
    rrpv_t                  max_rrpv;
    logic                   found;

    assign cur = lines_q[i_set];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            o_valid[w] = cur[w].valid;
        end
    end

    // --------------------
    // victim choice
    // --------------------
    always_comb begin
        max_rrpv = '0;
        found    = 1'b0;
        o_victim = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (cur[w].rrpv > max_rrpv) begin
                max_rrpv = cur[w].rrpv;
            end
        end
        // lowest invalid way first
        for (int w = 0; w < WAYS; w++) begin
            if (!found && !cur[w].valid) begin
                o_victim[w] = 1'b1;
                found       = 1'b1;
            end
        end
        // otherwise lowest way at the largest rrpv
        for (int w = 0; w < WAYS; w++) begin
            if (!found && cur[w].rrpv == max_rrpv) begin
                o_victim[w] = 1'b1;
                found       = 1'b1;
            end
        end
        o_victim_state = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (o_victim[w]) begin
                o_victim_state = cur[w];
            end
        end
    end

    // --------------------
    // srrip update
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < SETS; s++) begin
                lines_q[s] <= '0;
            end
        end else if (i_update) begin
            for (int w = 0; w < WAYS; w++) begin
                if (i_update_way[w]) begin
                    lines_q[i_set][w].valid <= 1'b1;
                    // a fetch hit keeps whatever dirty bit was there
                    lines_q[i_set][w].dirty <= i_set_dirty | (i_update_hit & cur[w].dirty);
                    lines_q[i_set][w].rrpv  <= i_update_hit ? '0 : RRPV_INSERT;
                end else if (cur[w].valid && cur[w].rrpv != RRPV_MAX) begin
                    lines_q[i_set][w].rrpv <= cur[w].rrpv + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_nreset)
        !$isunknown(i_set) |-> $onehot(o_victim))
        else $error("rrip_state: victim vector not one-hot");

endmodule

`default_nettype wire

//--- verilog/bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl (
    input  wire                          i_clk,
    input  wire                          i_nreset,
    // pe side
    input  wire  cache_pkg::req_t        i_req,
    input  wire                          i_req_valid,
    output logic                         o_req_ready,
    output cache_pkg::data_t             o_pe_data,
    output logic                         o_pe_valid,
    input  wire                          i_pe_ready,
    // dram side
    output cache_pkg::wb_t               o_dram_wr,
    output logic                         o_dram_wr_valid,
    input  wire                          i_dram_wr_ready,
    output cache_pkg::addr_t             o_dram_rd_addr,
    output logic                         o_dram_rd_req,
    input  wire  cache_pkg::data_t       i_dram_rd_data,
    input  wire                          i_dram_rd_valid,
    // arrays
    output cache_pkg::set_t              o_set,
    output logic                         o_rd_en,
    output cache_pkg::way_vec_t          o_tag_wr,
    output cache_pkg::way_vec_t          o_data_wr,
    output cache_pkg::tag_t              o_wr_tag,
    output cache_pkg::data_t             o_wr_data,
    input  wire                          i_hit,
    input  wire  cache_pkg::way_vec_t    i_hit_way,
    input  wire  cache_pkg::data_t       i_hit_data,
    input  wire  cache_pkg::way_vec_t    i_victim,
    input  wire  cache_pkg::line_state_t i_victim_state,
    input  wire  cache_pkg::tag_t        i_victim_tag,
    input  wire  cache_pkg::data_t       i_victim_data,
    // replacement state
    output logic                         o_update,
    output cache_pkg::way_vec_t          o_update_way,
    output logic                         o_update_hit,
    output logic                         o_set_dirty
);

    import cache_pkg::*;

    typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, RESPOND} state_t;

    state_t   state;
    state_t   state_nxt;
    req_t     req_q;
    way_vec_t victim_q;
    wb_t      wb_q;
    data_t    pe_data_q;
    logic     accept;
    logic     is_fetch;
    logic     victim_dirty;

    assign o_req_ready  = (state == IDLE);
    assign accept       = i_req_valid & o_req_ready;
    assign is_fetch     = (req_q.op == OP_FETCH);
    assign victim_dirty = i_victim_state.valid & i_victim_state.dirty;

    // incoming set while idle, latched set afterwards
    assign o_set     = (state == IDLE) ? i_req.addr[SET_BITS-1:0] : req_q.addr[SET_BITS-1:0];
    assign o_rd_en   = accept;
    assign o_wr_tag  = req_q.addr[ADDR_BITS-1:SET_BITS];
    assign o_wr_data = (state == REFILL) ? i_dram_rd_data : req_q.data;

    assign o_pe_data       = pe_data_q;
    assign o_pe_valid      = (state == RESPOND);
    assign o_dram_wr       = wb_q;
    assign o_dram_wr_valid = (state == WRITEBACK);
    assign o_dram_rd_addr  = req_q.addr;
    assign o_dram_rd_req   = (state == REFILL);

    always_comb begin
        state_nxt    = state;
        o_tag_wr     = '0;
        o_data_wr    = '0;
        o_update     = 1'b0;
        o_update_way = '0;
        o_update_hit = 1'b0;
        o_set_dirty  = 1'b0;
        case (state)
            // --------------------
            IDLE: begin
                if (accept) begin
                    state_nxt = LOOKUP;
                end
            end
            // --------------------
            LOOKUP: begin
                if (i_hit) begin
                    o_update     = 1'b1;
                    o_update_way = i_hit_way;
                    o_update_hit = 1'b1;
                    if (is_fetch) begin
                        state_nxt = RESPOND;
                    end else begin
                        o_data_wr   = i_hit_way;
                        o_set_dirty = 1'b1;
                        state_nxt   = IDLE;
                    end
                end else if (victim_dirty) begin
                    state_nxt = WRITEBACK;
                end else if (is_fetch) begin
                    state_nxt = REFILL;
                end else begin
                    // write miss into a clean victim, no refill
                    o_tag_wr     = i_victim;
                    o_data_wr    = i_victim;
                    o_update     = 1'b1;
                    o_update_way = i_victim;
                    o_set_dirty  = 1'b1;
                    state_nxt    = IDLE;
                end
            end
            // --------------------
            WRITEBACK: begin
                if (i_dram_wr_ready) begin
                    if (is_fetch) begin
                        state_nxt = REFILL;
                    end else begin
                        o_tag_wr     = victim_q;
                        o_data_wr    = victim_q;
                        o_update     = 1'b1;
                        o_update_way = victim_q;
                        o_set_dirty  = 1'b1;
                        state_nxt    = IDLE;
                    end
                end
            end
            // --------------------
            REFILL: begin
                if (i_dram_rd_valid) begin
                    o_tag_wr     = victim_q;
                    o_data_wr    = victim_q;
                    o_update     = 1'b1;
                    o_update_way = victim_q;
                    state_nxt    = RESPOND;
                end
            end
            // --------------------
            RESPOND: begin
                if (i_pe_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request, victim and response payload
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q <= i_req;
        end
        if (state == LOOKUP && !i_hit) begin
            victim_q <= i_victim;
        end
        if (state == LOOKUP && !i_hit && victim_dirty) begin
            wb_q.addr <= {i_victim_tag, req_q.addr[SET_BITS-1:0]};
            wb_q.data <= i_victim_data;
        end
        if (state == LOOKUP && i_hit) begin
            pe_data_q <= i_hit_data;
        end else if (state == REFILL && i_dram_rd_valid) begin
            pe_data_q <= i_dram_rd_data;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_nreset)
        o_pe_valid && !i_pe_ready |=> o_pe_valid && $stable(o_pe_data))
        else $error("bank_ctrl: response dropped or changed before handshake");

endmodule

`default_nettype wire

//--- verilog/cache_bank.sv
`timescale 1ns/1ps
`default_nettype none

module cache_bank (
    input  wire                    i_clk,
    input  wire                    i_nreset,
    // pe side
    input  wire  cache_pkg::req_t  i_req,
    input  wire                    i_req_valid,
    output logic                   o_req_ready,
    output cache_pkg::data_t       o_pe_data,
    output logic                   o_pe_valid,
    input  wire                    i_pe_ready,
    // dram side
    output cache_pkg::wb_t         o_dram_wr,
    output logic                   o_dram_wr_valid,
    input  wire                    i_dram_wr_ready,
    output cache_pkg::addr_t       o_dram_rd_addr,
    output logic                   o_dram_rd_req,
    input  wire  cache_pkg::data_t i_dram_rd_data,
    input  wire                    i_dram_rd_valid
);

    import cache_pkg::*;

    set_t               set;
    logic               rd_en;
    way_vec_t           tag_wr;
    way_vec_t           data_wr;
    tag_t               wr_tag;
    data_t              wr_data;
    tag_t  [WAYS-1:0]   way_tags;
    data_t [WAYS-1:0]   way_data;
    way_vec_t           valid;
    way_vec_t           hit_way;
    logic               hit;
    data_t              hit_data;
    way_vec_t           victim;
    line_state_t        victim_state;
    tag_t               victim_tag;
    data_t              victim_data;
    logic               update;
    way_vec_t           update_way;
    logic               update_hit;
    logic               set_dirty;

    // --------------------
    // storage per way
    // --------------------
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_array #(.payload_t(tag_t)) tag_ways (
            .i_clk     (i_clk),
            .i_set     (set),
            .i_rd_en   (rd_en),
            .i_wr_en   (tag_wr[w]),
            .i_wr_data (wr_tag),
            .o_rd_data (way_tags[w])
        );

        way_array #(.payload_t(data_t)) data_ways (
            .i_clk     (i_clk),
            .i_set     (set),
            .i_rd_en   (rd_en),
            .i_wr_en   (data_wr[w]),
            .i_wr_data (wr_data),
            .o_rd_data (way_data[w])
        );
    end

    // victim tag and word for the write-back
    always_comb begin
        victim_tag  = '0;
        victim_data = '0;
        for (int w = 0; w < WAYS; w++) begin
            victim_tag  = victim_tag | (way_tags[w] & {TAG_BITS{victim[w]}});
            victim_data = victim_data | (way_data[w] & {DATA_BITS{victim[w]}});
        end
    end

    tag_match u_tag_match (
        .i_tag      (wr_tag),
        .i_way_tags (way_tags),
        .i_way_data (way_data),
        .i_valid    (valid),
        .o_hit_way  (hit_way),
        .o_hit      (hit),
        .o_hit_data (hit_data)
    );

    rrip_state u_rrip_state (
        .i_clk          (i_clk),
        .i_nreset       (i_nreset),
        .i_set          (set),
        .i_update       (update),
        .i_update_way   (update_way),
        .i_update_hit   (update_hit),
        .i_set_dirty    (set_dirty),
        .o_victim       (victim),
        .o_victim_state (victim_state),
        .o_valid        (valid)
    );

    bank_ctrl u_bank_ctrl (
        .i_clk           (i_clk),
        .i_nreset        (i_nreset),
        .i_req           (i_req),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .o_pe_data       (o_pe_data),
        .o_pe_valid      (o_pe_valid),
        .i_pe_ready      (i_pe_ready),
        .o_dram_wr       (o_dram_wr),
        .o_dram_wr_valid (o_dram_wr_valid),
        .i_dram_wr_ready (i_dram_wr_ready),
        .o_dram_rd_addr  (o_dram_rd_addr),
        .o_dram_rd_req   (o_dram_rd_req),
        .i_dram_rd_data  (i_dram_rd_data),
        .i_dram_rd_valid (i_dram_rd_valid),
        .o_set           (set),
        .o_rd_en         (rd_en),
        .o_tag_wr        (tag_wr),
        .o_data_wr       (data_wr),
        .o_wr_tag        (wr_tag),
        .o_wr_data       (wr_data),
        .i_hit           (hit),
        .i_hit_way       (hit_way),
        .i_hit_data      (hit_data),
        .i_victim        (victim),
        .i_victim_state  (victim_state),
        .i_victim_tag    (victim_tag),
        .i_victim_data   (victim_data),
        .o_update        (update),
        .o_update_way    (update_way),
        .o_update_hit    (update_hit),
        .o_set_dirty     (set_dirty)
    );

endmodule

`default_nettype wire

//--- bench/dram_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_model (
    input  wire                    i_clk,
    input  wire                    i_nreset,
    input  wire  cache_pkg::wb_t   i_wr,
    input  wire                    i_wr_valid,
    output logic                   o_wr_ready,
    input  wire  cache_pkg::addr_t i_rd_addr,
    input  wire                    i_rd_req,
    output cache_pkg::data_t       o_rd_data,
    output logic                   o_rd_valid,
    output logic                   o_pe_ready
);

    import cache_pkg::*;

    data_t       mem [1 << ADDR_BITS];
    logic [15:0] lfsr = 16'd96;
    logic [3:0]  wr_wait;
    logic [3:0]  rd_wait;
    logic        wr_fire;
    logic        rd_fire;
    wb_t         wr_word;

    // galois lfsr, one step per bit taken
    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    initial begin
        o_wr_ready = 1'b0;
        o_rd_valid = 1'b0;
        o_rd_data  = '0;
        o_pe_ready = 1'b0;
        wr_fire    = 1'b0;
        rd_fire    = 1'b0;
        wr_wait    = '0;
        rd_wait    = '0;
        // initial word is the inverted address
        for (int a = 0; a < (1 << ADDR_BITS); a++) begin
            mem[a] = ~data_t'(a);
        end
    end

    // handshakes that complete at the next rising edge
    always @(negedge i_clk) begin
        wr_fire = i_wr_valid && o_wr_ready;
        rd_fire = i_rd_req && o_rd_valid;
        wr_word = i_wr;
    end

    always @(posedge i_clk) begin
        #1;
        if (!i_nreset) begin
            o_wr_ready = 1'b0;
            o_rd_valid = 1'b0;
            o_pe_ready = 1'b0;
            wr_wait    = rand_bits(2);
            rd_wait    = rand_bits(3);
        end else begin
            // --------------------
            // write-back channel
            // --------------------
            if (wr_fire) begin
                mem[wr_word.addr] = wr_word.data;
                o_wr_ready        = 1'b0;
                wr_wait           = rand_bits(2);
            end else if (i_wr_valid && !o_wr_ready) begin
                if (wr_wait == 0) begin
                    o_wr_ready = 1'b1;
                end else begin
                    wr_wait = wr_wait - 1'b1;
                end
            end
            // --------------------
            // refill channel
            // --------------------
            if (rd_fire) begin
                o_rd_valid = 1'b0;
                o_rd_data  = '0;
                rd_wait    = rand_bits(3);
            end else if (i_rd_req && !o_rd_valid) begin
                if (rd_wait == 0) begin
                    o_rd_valid = 1'b1;
                    o_rd_data  = mem[i_rd_addr];
                end else begin
                    rd_wait = rd_wait - 1'b1;
                end
            end
            // pe ready roughly three cycles in four
            o_pe_ready = (rand_bits(2) != 4'd0);
        end
    end

endmodule

`default_nettype wire

//--- bench/cache_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_bank_tb;

    import cache_pkg::*;

    localparam int CYCLES_PER_VEC = 64;

    typedef struct packed {
        op_t         op;
        addr_t       addr;
        data_t       data;
        data_t       exp_data;
        logic [15:0] exp_wb;
        logic        exp_rd;
    } vec_t;

    logic  clk;
    logic  nreset;
    req_t  req;
    logic  req_valid;
    logic  req_ready;
    data_t pe_data;
    logic  pe_valid;
    logic  pe_ready;
    wb_t   dram_wr;
    logic  dram_wr_valid;
    logic  dram_wr_ready;
    addr_t dram_rd_addr;
    logic  dram_rd_req;
    data_t dram_rd_data;
    logic  dram_rd_valid;

    vec_t  vecs [$];
    data_t written [addr_t];
    logic  loaded = 1'b0;
    int    mismatches = 0;
    int    failures = 0;
    int    wb_count = 0;
    int    rd_cycles = 0;
    wb_t   last_wb;
    addr_t cur_addr = '0;
    logic  pe_pending = 1'b0;
    data_t pe_held;

    cache_bank dut0 (
        .i_clk           (clk),
        .i_nreset        (nreset),
        .i_req           (req),
        .i_req_valid     (req_valid),
        .o_req_ready     (req_ready),
        .o_pe_data       (pe_data),
        .o_pe_valid      (pe_valid),
        .i_pe_ready      (pe_ready),
        .o_dram_wr       (dram_wr),
        .o_dram_wr_valid (dram_wr_valid),
        .i_dram_wr_ready (dram_wr_ready),
        .o_dram_rd_addr  (dram_rd_addr),
        .o_dram_rd_req   (dram_rd_req),
        .i_dram_rd_data  (dram_rd_data),
        .i_dram_rd_valid (dram_rd_valid)
    );

    dram_model dram0 (
        .i_clk      (clk),
        .i_nreset   (nreset),
        .i_wr       (dram_wr),
        .i_wr_valid (dram_wr_valid),
        .o_wr_ready (dram_wr_ready),
        .i_rd_addr  (dram_rd_addr),
        .i_rd_req   (dram_rd_req),
        .o_rd_data  (dram_rd_data),
        .o_rd_valid (dram_rd_valid),
        .o_pe_ready (pe_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_wb(input string name, input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        failures++;
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    f_op;
        int    f_addr;
        int    f_data;
        int    f_exp;
        int    f_wb;
        int    f_rd;
        string line;
        vec_t  v;
        fd = $fopen("bench/bank_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open bench/bank_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // comment lines do not parse and are skipped
            if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
                    f_op, f_addr, f_data, f_exp, f_wb, f_rd) == 6) begin
                v.op       = f_op[0] ? OP_WRITE : OP_FETCH;
                v.addr     = addr_t'(f_addr);
                v.data     = data_t'(f_data);
                v.exp_data = data_t'(f_exp);
                v.exp_wb   = f_wb[15:0];
                v.exp_rd   = f_rd[0];
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // pe driver
    // --------------------
    task automatic run_vector(input vec_t v);
        req_t  r;
        int    wb_before;
        int    rd_before;
        data_t got;
        wb_t   exp_wb;
        r.op      = v.op;
        r.addr    = v.addr;
        r.data    = v.data;
        wb_before = wb_count;
        rd_before = rd_cycles;
        cur_addr  = v.addr;
        req       = r;
        req_valid = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (v.op == OP_FETCH) begin
            do @(negedge clk); while (!(pe_valid && pe_ready));
            got = pe_data;
            @(posedge clk);
            #1;
            check_data("o_pe_data", got, v.exp_data);
        end else begin
            // a write ends when the bank is ready again
            do @(negedge clk); while (!req_ready);
            @(posedge clk);
            #1;
        end
        if (v.exp_wb == 16'hffff) begin
            if (wb_count != wb_before) begin
                report_failure($sformatf("request to %h wrote back %h without cause",
                    v.addr, last_wb.addr));
            end
        end else if (wb_count != wb_before + 1) begin
            report_failure($sformatf("request to %h expected one write-back, saw %0d",
                v.addr, wb_count - wb_before));
        end else if (!written.exists(addr_t'(v.exp_wb))) begin
            report_failure($sformatf("write-back of %h that was never written", v.exp_wb));
        end else begin
            exp_wb.addr = addr_t'(v.exp_wb);
            exp_wb.data = written[exp_wb.addr];
            check_wb("o_dram_wr", last_wb, exp_wb);
            check_data("shadow memory", dram0.mem[exp_wb.addr], exp_wb.data);
        end
        if ((rd_cycles != rd_before) != v.exp_rd) begin
            report_failure($sformatf("request to %h: DRAM read expected %0d, seen %0d",
                v.addr, v.exp_rd, rd_cycles != rd_before));
        end
        if (v.op == OP_WRITE) begin
            written[v.addr] = v.data;
        end
    endtask

    // dram traffic and response stability sampled mid-cycle
    always @(negedge clk) begin
        if (nreset) begin
            if (dram_wr_valid && dram_wr_ready) begin
                wb_count++;
                last_wb = dram_wr;
            end
            if (dram_rd_req) begin
                rd_cycles++;
                check_addr("o_dram_rd_addr", dram_rd_addr, cur_addr);
            end
            if (pe_pending) begin
                check_ready("o_pe_valid held", pe_valid, 1'b1);
                check_data("o_pe_data held", pe_data, pe_held);
            end
            if (pe_valid && req_ready) begin
                report_failure("o_req_ready high while a response is pending");
            end
            pe_pending = pe_valid && !pe_ready;
            pe_held    = pe_data;
        end
    end

    initial begin
        nreset    = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        nreset = 1'b1;
        @(negedge clk);
        check_ready("o_req_ready", req_ready, 1'b1);
        check_ready("o_pe_valid", pe_valid, 1'b0);
        check_ready("o_dram_wr_valid", dram_wr_valid, 1'b0);
        check_ready("o_dram_rd_req", dram_rd_req, 1'b0);
        @(posedge clk);
        #1;
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (vecs.size() * CYCLES_PER_VEC + 20) @(posedge clk);
        $display("timeout: requests did not complete in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/cache_pkg.sv
verilog/way_array.sv
verilog/tag_match.sv
verilog/rrip_state.sv
verilog/bank_ctrl.sv
verilog/cache_bank.sv
bench/dram_model.sv
bench/cache_bank_tb.sv

//--- Makefile
# Verilator build and run for the cache bank testbench

TOOL       = verilator
TOP        = cache_bank_tb
RTL_TOP    = cache_bank
FILELIST   = compile.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/bank_vectors.txt
# op(0 fetch, 1 write) addr data exp_data exp_wb_addr(ffff none) exp_dram_read
# all values hex, address is {tag, set}
0 123 0000 fedc ffff 1
0 123 0000 fedc ffff 0
1 045 beef 0000 ffff 0
0 045 0000 beef ffff 0
1 123 5a5a 0000 ffff 0
0 123 0000 5a5a ffff 0
# set 7 fills four ways, then replacement
0 017 0000 ffe8 ffff 1
0 027 0000 ffd8 ffff 1
0 037 0000 ffc8 ffff 1
0 047 0000 ffb8 ffff 1
0 017 0000 ffe8 ffff 0
0 057 0000 ffa8 ffff 1
0 027 0000 ffd8 ffff 1
0 017 0000 ffe8 ffff 0
# set 9 dirty lines and write-backs
1 019 1111 0000 ffff 0
1 029 2222 0000 ffff 0
1 039 3333 0000 ffff 0
1 019 1a1a 0000 ffff 0
1 049 4444 0000 ffff 0
0 059 0000 ffa6 0029 1
1 069 6666 0000 0039 0
0 029 0000 2222 0019 1
0 019 0000 1a1a ffff 1
0 039 0000 3333 ffff 1
0 0ff 0000 ff00 ffff 1
